//--- src/udma_rx_pkg.sv
// shared definitions of the receive DMA block
// N_CH and FIFO_DEPTH must stay powers of two
// register address is {channel, offset}, offsets 0 start address, 1 size, 2 control
`default_nettype none

package udma_rx_pkg;

    localparam int N_CH          = 4;
    localparam int CH_BITS       = $clog2(N_CH);
    localparam int DATA_WIDTH    = 32;
    localparam int L2_DATA_WIDTH = 32;
    localparam int L2_AWIDTH     = 16;
    localparam int TRANS_SIZE    = 16;
    localparam int ALIGN_BITS    = 2;
    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_AW       = $clog2(FIFO_DEPTH);

    localparam logic [7:0] L2_BASE_HI = 8'h1C;

    ////////////////////
    // register map
    localparam int         CFG_AWIDTH = 4;
    localparam int         REG_OFS_W  = CFG_AWIDTH - CH_BITS;
    localparam logic [1:0] REG_SADDR  = 2'd0;
    localparam logic [1:0] REG_SIZE   = 2'd1;
    localparam logic [1:0] REG_CTRL   = 2'd2;   // bit0 en, bit1 continuous, bit2 clr

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } datasize_e;

    typedef struct packed {
        logic [L2_AWIDTH-1:0]  start_addr;
        logic [TRANS_SIZE-1:0] size;
        logic                  continuous;
        logic                  en;
    } ch_cfg_t;

    typedef struct packed {
        logic [L2_AWIDTH-1:0]  curr_addr;
        logic [TRANS_SIZE-1:0] bytes_left;
        logic                  pending;
        logic                  en;
    } ch_status_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
        datasize_e             datasize;
    } ch_in_t;

    // one write FIFO entry, bytes_m1 is the byte count of the beat minus one
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [L2_AWIDTH-1:0]  addr;
        datasize_e             datasize;
        logic [1:0]            bytes_m1;
    } l2_beat_t;

    typedef struct packed {
        logic [31:0]                addr;
        logic [L2_DATA_WIDTH/8-1:0] be;
        logic [L2_DATA_WIDTH-1:0]   wdata;
    } l2_wr_t;

endpackage

`default_nettype wire

//--- src/udma_rx_cfg_regs.sv
// channel configuration registers behind a plain write strobe
// writes to offset 3 are ignored, the registers cannot be read back
`timescale 1ns/1ps
`default_nettype none

module udma_rx_cfg_regs (
    input  logic                                          clk_i,
    input  logic                                          rstn_i,
    input  logic                                          cfg_we_i,
    input  logic [udma_rx_pkg::CFG_AWIDTH-1:0]            cfg_addr_i,
    input  logic [31:0]                                   cfg_wdata_i,
    output udma_rx_pkg::ch_cfg_t [udma_rx_pkg::N_CH-1:0]  ch_cfg_o,
    output logic [udma_rx_pkg::N_CH-1:0]                  ch_clr_o
);

    logic [udma_rx_pkg::CH_BITS-1:0]   ch_sel;
    logic [udma_rx_pkg::REG_OFS_W-1:0] reg_ofs;

    assign ch_sel  = cfg_addr_i[udma_rx_pkg::CFG_AWIDTH-1:udma_rx_pkg::REG_OFS_W];
    assign reg_ofs = cfg_addr_i[udma_rx_pkg::REG_OFS_W-1:0];

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            ch_cfg_o <= '0;
            ch_clr_o <= '0;
        end
        else
        begin
            ch_clr_o <= '0;     // clr never stays set, it lasts one cycle
            if (cfg_we_i)
            begin
                case (reg_ofs)
                    udma_rx_pkg::REG_SADDR:
                        ch_cfg_o[ch_sel].start_addr <= cfg_wdata_i[udma_rx_pkg::L2_AWIDTH-1:0];
                    udma_rx_pkg::REG_SIZE:
                        ch_cfg_o[ch_sel].size <= cfg_wdata_i[udma_rx_pkg::TRANS_SIZE-1:0];
                    udma_rx_pkg::REG_CTRL:
                    begin
                        ch_cfg_o[ch_sel].en         <= cfg_wdata_i[0];
                        ch_cfg_o[ch_sel].continuous <= cfg_wdata_i[1];
                        ch_clr_o[ch_sel]            <= cfg_wdata_i[2];
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/udma_rx_ch_addrgen.sv
// linear address generator of one receive channel
// a rising en or a clr restarts the transfer from the configured start
// a beat sampled after the last one but before en drops is stepped over
`timescale 1ns/1ps
`default_nettype none

module udma_rx_ch_addrgen (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  udma_rx_pkg::ch_cfg_t    cfg_i,
    input  logic                    clr_i,
    input  logic                    step_i,
    input  udma_rx_pkg::datasize_e  datasize_i,
    output udma_rx_pkg::ch_status_t status_o,
    output logic [1:0]              beat_bytes_o,
    output logic                    event_o
);

    logic                               en_prev_q;
    logic                               pending_q;
    logic                               run_q;
    logic [udma_rx_pkg::L2_AWIDTH-1:0]  addr_q;
    logic [udma_rx_pkg::TRANS_SIZE-1:0] left_q;
    logic [udma_rx_pkg::L2_AWIDTH-1:0]  addr_inc;
    logic [udma_rx_pkg::TRANS_SIZE-1:0] left_dec;
    logic [2:0]                         size_bytes;
    logic [2:0]                         n_bytes;
    logic                               start;
    logic                               last;

    always_comb
    begin
        case (datasize_i)
            udma_rx_pkg::SIZE_BYTE: size_bytes = 3'd1;
            udma_rx_pkg::SIZE_HALF: size_bytes = 3'd2;
            default:                size_bytes = 3'd4;
        endcase
    end

    assign addr_inc = {{(udma_rx_pkg::L2_AWIDTH-3){1'b0}}, size_bytes};
    assign left_dec = {{(udma_rx_pkg::TRANS_SIZE-3){1'b0}}, size_bytes};
    assign start    = (cfg_i.en & ~en_prev_q) | clr_i;
    assign last     = left_q <= left_dec;       // this beat uses up the transfer

    // the last beat is trimmed to the bytes still left
    assign n_bytes      = last ? left_q[2:0] : size_bytes;
    assign beat_bytes_o = n_bytes[1:0] - 2'd1;
    assign event_o      = step_i & run_q & last;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            en_prev_q <= 1'b0;
            pending_q <= 1'b0;
            run_q     <= 1'b0;
            addr_q    <= '0;
            left_q    <= '0;
        end
        else
        begin
            en_prev_q <= cfg_i.en;
            if (start)
            begin
                addr_q    <= cfg_i.start_addr;
                left_q    <= cfg_i.size;
                pending_q <= 1'b1;
                run_q     <= 1'b1;
            end
            else if (step_i && run_q)
            begin
                if (last)
                begin
                    addr_q    <= cfg_i.start_addr;
                    left_q    <= cfg_i.size;
                    pending_q <= cfg_i.continuous;  // continuous mode runs on from the start
                    run_q     <= cfg_i.continuous;
                end
                else
                begin
                    addr_q <= addr_q + addr_inc;
                    left_q <= left_q - left_dec;
                end
            end
        end
    end

    always_comb
    begin
        status_o.curr_addr  = addr_q;
        status_o.bytes_left = left_q;
        status_o.pending    = pending_q;
        status_o.en         = run_q;
    end

endmodule

`default_nettype wire

//--- src/udma_rx_arbiter.sv
// round-robin arbiter, the grant is combinational from the requests
// the search starts after the channel that was served last
`timescale 1ns/1ps
`default_nettype none

module udma_rx_arbiter (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic [udma_rx_pkg::N_CH-1:0] req_i,
    input  logic                         ack_i,
    output logic [udma_rx_pkg::N_CH-1:0] grant_o,
    output logic                         any_grant_o
);

    logic [udma_rx_pkg::CH_BITS-1:0] last_q;
    logic [udma_rx_pkg::CH_BITS-1:0] idx;
    logic [udma_rx_pkg::CH_BITS-1:0] pick;

    always_comb
    begin
        grant_o = '0;
        pick    = last_q;
        idx     = last_q;
        for (int i = 0; i < udma_rx_pkg::N_CH; i++)
        begin
            idx = idx + 1'b1;   // wraps around the channel count
            if (grant_o == '0 && req_i[idx])
            begin
                grant_o[idx] = 1'b1;
                pick         = idx;
            end
        end
    end

    assign any_grant_o = |grant_o;

    ////////////////////
    // priority pointer

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            last_q <= '1;       // channel 0 wins first
        else if (ack_i && any_grant_o)
            last_q <= pick;
    end

endmodule

`default_nettype wire

//--- src/udma_rx_fifo.sv
// write FIFO between the input register and the L2 port
// the head is valid one cycle after a push, a push while full is dropped
`timescale 1ns/1ps
`default_nettype none

module udma_rx_fifo (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  push_i,
    input  udma_rx_pkg::l2_beat_t data_i,
    output logic                  full_o,
    input  logic                  pop_i,
    output logic                  valid_o,
    output udma_rx_pkg::l2_beat_t data_o
);

    udma_rx_pkg::l2_beat_t             mem_q [udma_rx_pkg::FIFO_DEPTH];
    logic [udma_rx_pkg::FIFO_AW-1:0]   wr_ptr_q;
    logic [udma_rx_pkg::FIFO_AW-1:0]   rd_ptr_q;
    logic [udma_rx_pkg::FIFO_AW:0]     count_q;
    logic                              do_push;
    logic                              do_pop;

    assign full_o  = count_q[udma_rx_pkg::FIFO_AW];     // count equals the depth
    assign valid_o = |count_q;
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem_q[wr_ptr_q] <= data_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (do_pop && !do_push)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/udma_rx_l2_write.sv
// turns FIFO beats into byte-enabled writes on the 32-bit L2 port
// a beat crossing a word boundary is split in two writes, low bytes first
// the request follows the FIFO head, the head is popped on the last grant only
`timescale 1ns/1ps
`default_nettype none

module udma_rx_l2_write (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  beat_valid_i,
    input  udma_rx_pkg::l2_beat_t beat_i,
    output logic                  beat_pop_o,
    output logic                  l2_req_o,
    output udma_rx_pkg::l2_wr_t   l2_wr_o,
    input  logic                  l2_gnt_i
);

    enum logic {WR_FIRST, WR_SECOND} state_q, state_d;

    logic [2:0]                                                 n_bytes;
    logic [udma_rx_pkg::ALIGN_BITS-1:0]                         ofs;
    logic [7:0]                                                 lane_mask;
    logic [7:0]                                                 be_wide;
    logic [63:0]                                                data_wide;
    logic                                                       split;
    logic                                                       second;
    logic [udma_rx_pkg::L2_AWIDTH-udma_rx_pkg::ALIGN_BITS-1:0]  word_addr;

    assign n_bytes = {1'b0, beat_i.bytes_m1} + 3'd1;
    assign ofs     = beat_i.addr[udma_rx_pkg::ALIGN_BITS-1:0];

    ////////////////////
    // lane placement over two words

    always_comb
    begin
        lane_mask = (8'd1 << n_bytes) - 8'd1;
        be_wide   = lane_mask << ofs;
        data_wide = {32'h0, beat_i.data} << {ofs, 3'b000};
        for (int b = 0; b < 8; b++)
        begin
            if (!be_wide[b])
                data_wide[8*b +: 8] = 8'h00;   // bytes past the beat never reach the bus
        end
    end

    assign split     = |be_wide[7:4];
    assign second    = (state_q == WR_SECOND);
    assign word_addr = beat_i.addr[udma_rx_pkg::L2_AWIDTH-1:udma_rx_pkg::ALIGN_BITS] + second;

    always_comb
    begin
        l2_wr_o.addr  = {udma_rx_pkg::L2_BASE_HI, {(24-udma_rx_pkg::L2_AWIDTH){1'b0}},
                         word_addr, {udma_rx_pkg::ALIGN_BITS{1'b0}}};
        l2_wr_o.be    = second ? be_wide[7:4] : be_wide[3:0];
        l2_wr_o.wdata = second ? data_wide[63:32] : data_wide[31:0];
    end

    assign l2_req_o = beat_valid_i;

    ////////////////////
    // misalignment FSM

    always_comb
    begin
        state_d    = state_q;
        beat_pop_o = 1'b0;
        case (state_q)
            WR_FIRST:
            begin
                if (beat_valid_i && l2_gnt_i)
                begin
                    if (split)
                        state_d = WR_SECOND;    // upper bytes go to the next word
                    else
                        beat_pop_o = 1'b1;
                end
            end
            WR_SECOND:
            begin
                if (beat_valid_i && l2_gnt_i)
                begin
                    state_d    = WR_FIRST;
                    beat_pop_o = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= WR_FIRST;
        else
            state_q <= state_d;
    end

endmodule

`default_nettype wire

//--- src/udma_rx_top.sv
// receive DMA block, four linear channels written into L2 through a 32-bit port
// first request comes two or more cycles after a beat is sampled
// requests and their contents hold until l2_gnt_i, split beats need two grants
// ready only rises for the granted channel while the write FIFO has room
`timescale 1ns/1ps
`default_nettype none

module udma_rx_top (
    input  logic                                            clk_i,
    input  logic                                            rstn_i,
    input  logic                                            cfg_we_i,
    input  logic [udma_rx_pkg::CFG_AWIDTH-1:0]              cfg_addr_i,
    input  logic [31:0]                                     cfg_wdata_i,
    input  udma_rx_pkg::ch_in_t [udma_rx_pkg::N_CH-1:0]     ch_in_i,
    output logic [udma_rx_pkg::N_CH-1:0]                    ch_ready_o,
    output udma_rx_pkg::ch_status_t [udma_rx_pkg::N_CH-1:0] ch_status_o,
    output logic [udma_rx_pkg::N_CH-1:0]                    ch_event_o,
    output logic                                            l2_req_o,
    output udma_rx_pkg::l2_wr_t                             l2_wr_o,
    input  logic                                            l2_gnt_i
);

    udma_rx_pkg::ch_cfg_t [udma_rx_pkg::N_CH-1:0] ch_cfg;
    logic [udma_rx_pkg::N_CH-1:0]                 ch_clr;
    logic [udma_rx_pkg::N_CH-1:0][1:0]            beat_bytes;
    logic [udma_rx_pkg::N_CH-1:0]                 req;
    logic [udma_rx_pkg::N_CH-1:0]                 grant;
    logic [udma_rx_pkg::N_CH-1:0]                 step;
    logic                                         any_grant;
    logic                                         sample;
    logic                                         push;
    logic                                         fifo_full;
    logic [udma_rx_pkg::DATA_WIDTH-1:0]           s_data;
    udma_rx_pkg::datasize_e                       s_size;
    logic                                         r_valid;
    logic [udma_rx_pkg::N_CH-1:0]                 r_grant;
    logic [udma_rx_pkg::DATA_WIDTH-1:0]           r_data;
    udma_rx_pkg::datasize_e                       r_size;
    udma_rx_pkg::l2_beat_t                        beat_in;
    udma_rx_pkg::l2_beat_t                        beat_head;
    logic                                         head_valid;
    logic                                         head_pop;

    assign sample = any_grant & ~fifo_full;
    assign push   = r_valid & ~fifo_full;   // a full FIFO holds the input register
    assign step   = {udma_rx_pkg::N_CH{push}} & r_grant;

    always_comb
    begin
        s_data = '0;
        s_size = udma_rx_pkg::SIZE_BYTE;
        for (int i = 0; i < udma_rx_pkg::N_CH; i++)
        begin
            req[i]        = ch_in_i[i].valid & ch_status_o[i].en;
            ch_ready_o[i] = grant[i] & sample;
            if (grant[i])
            begin
                s_data = ch_in_i[i].data;
                s_size = ch_in_i[i].datasize;
            end
        end
    end

    ////////////////////
    // input register

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_valid <= 1'b0;
            r_grant <= '0;
        end
        else if (!fifo_full)
        begin
            r_valid <= sample;
            if (sample)
                r_grant <= grant;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (sample)
        begin
            r_data <= s_data;
            r_size <= s_size;
        end
    end

    // address and byte count come from the channel that owns the registered beat
    always_comb
    begin
        beat_in.data     = r_data;
        beat_in.datasize = r_size;
        beat_in.addr     = '0;
        beat_in.bytes_m1 = '0;
        for (int i = 0; i < udma_rx_pkg::N_CH; i++)
        begin
            if (r_grant[i])
            begin
                beat_in.addr     = ch_status_o[i].curr_addr;
                beat_in.bytes_m1 = beat_bytes[i];
            end
        end
    end

    udma_rx_cfg_regs u_cfg_regs (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .cfg_we_i    ( cfg_we_i    ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_wdata_i ( cfg_wdata_i ),
        .ch_cfg_o    ( ch_cfg      ),
        .ch_clr_o    ( ch_clr      )
    );

    for (genvar j = 0; j < udma_rx_pkg::N_CH; j++)
    begin : g_ch
        udma_rx_ch_addrgen u_addrgen (
            .clk_i        ( clk_i          ),
            .rstn_i       ( rstn_i         ),
            .cfg_i        ( ch_cfg[j]      ),
            .clr_i        ( ch_clr[j]      ),
            .step_i       ( step[j]        ),
            .datasize_i   ( r_size         ),
            .status_o     ( ch_status_o[j] ),
            .beat_bytes_o ( beat_bytes[j]  ),
            .event_o      ( ch_event_o[j]  )
        );
    end

    udma_rx_arbiter u_arbiter (
        .clk_i       ( clk_i     ),
        .rstn_i      ( rstn_i    ),
        .req_i       ( req       ),
        .ack_i       ( sample    ),
        .grant_o     ( grant     ),
        .any_grant_o ( any_grant )
    );

    udma_rx_fifo u_fifo (
        .clk_i   ( clk_i      ),
        .rstn_i  ( rstn_i     ),
        .push_i  ( push       ),
        .data_i  ( beat_in    ),
        .full_o  ( fifo_full  ),
        .pop_i   ( head_pop   ),
        .valid_o ( head_valid ),
        .data_o  ( beat_head  )
    );

    udma_rx_l2_write u_l2_write (
        .clk_i        ( clk_i      ),
        .rstn_i       ( rstn_i     ),
        .beat_valid_i ( head_valid ),
        .beat_i       ( beat_head  ),
        .beat_pop_o   ( head_pop   ),
        .l2_req_o     ( l2_req_o   ),
        .l2_wr_o      ( l2_wr_o    ),
        .l2_gnt_i     ( l2_gnt_i   )
    );

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
// clock and reset for the testbench, 20 ns period
// reset is released on a falling edge after two rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 2;

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial
    begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_udma_rx.sv
// testbench of the receive DMA block, stimulus on the falling edge
// expected writes are matched by address, so channel address ranges must not overlap
`timescale 1ns/1ps
`default_nettype none

module tb_udma_rx;

    localparam int SETTLE_NS     = 1;
    localparam int BEAT_TIMEOUT  = 200;
    localparam int START_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 3000;
    localparam int RESET_TIMEOUT = 10;

    logic                                                  clk;
    logic                                                  rstn;
    logic                                                  cfg_we;
    logic [udma_rx_pkg::CFG_AWIDTH-1:0]                    cfg_addr;
    logic [31:0]                                           cfg_wdata;
    udma_rx_pkg::ch_in_t [udma_rx_pkg::N_CH-1:0]           ch_in;
    logic [udma_rx_pkg::N_CH-1:0]                          ch_ready;
    udma_rx_pkg::ch_status_t [udma_rx_pkg::N_CH-1:0]       ch_status;
    logic [udma_rx_pkg::N_CH-1:0]                          ch_event;
    logic                                                  l2_req;
    udma_rx_pkg::l2_wr_t                                   l2_wr;
    logic                                                  l2_gnt;

    udma_rx_pkg::l2_wr_t exp_q[$];      // scoreboard of writes still to come
    int                  event_count [udma_rx_pkg::N_CH];
    int                  n_checks;
    int                  n_errors;
    logic                gnt_random;
    logic                full_seen;
    string               test_name;

    tb_clkgen u_clkgen (
        .clk_o  ( clk  ),
        .rstn_o ( rstn )
    );

    udma_rx_top u_dut (
        .clk_i       ( clk       ),
        .rstn_i      ( rstn      ),
        .cfg_we_i    ( cfg_we    ),
        .cfg_addr_i  ( cfg_addr  ),
        .cfg_wdata_i ( cfg_wdata ),
        .ch_in_i     ( ch_in     ),
        .ch_ready_o  ( ch_ready  ),
        .ch_status_o ( ch_status ),
        .ch_event_o  ( ch_event  ),
        .l2_req_o    ( l2_req    ),
        .l2_wr_o     ( l2_wr     ),
        .l2_gnt_i    ( l2_gnt    )
    );

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        n_checks++;
        if (expected !== actual)
        begin
            n_errors++;
            $display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    function automatic int beat_size_bytes(input udma_rx_pkg::datasize_e ds);
        case (ds)
            udma_rx_pkg::SIZE_BYTE: return 1;
            udma_rx_pkg::SIZE_HALF: return 2;
            default:                return 4;
        endcase
    endfunction

    // byte k of the beat lands in lane a+k, lanes 4 and up spill into the next word
    function automatic int expected_writes(input logic [15:0] addr, input logic [31:0] data,
                                           input udma_rx_pkg::datasize_e ds, input int left,
                                           output udma_rx_pkg::l2_wr_t w0,
                                           output udma_rx_pkg::l2_wr_t w1);
        int n;
        int a;
        int k;
        int lane;
        n       = (left < beat_size_bytes(ds)) ? left : beat_size_bytes(ds);
        a       = addr[1:0];
        w0      = '0;
        w1      = '0;
        w0.addr = {udma_rx_pkg::L2_BASE_HI, 8'h00, addr[15:2], 2'b00};
        w1.addr = w0.addr + 32'd4;
        for (k = 0; k < n; k++)
        begin
            lane = a + k;
            if (lane < 4)
            begin
                w0.be[lane]            = 1'b1;
                w0.wdata[8*lane +: 8]  = data[8*k +: 8];
            end
            else
            begin
                w1.be[lane-4]             = 1'b1;
                w1.wdata[8*(lane-4) +: 8] = data[8*k +: 8];
            end
        end
        return (a + n > 4) ? 2 : 1;
    endfunction

    task automatic compare_write(input udma_rx_pkg::l2_wr_t got);
        int idx;
        int i;
        idx = -1;
        for (i = 0; i < exp_q.size() && idx < 0; i++)
        begin
            if (exp_q[i].addr == got.addr)
                idx = i;
        end
        if (idx < 0)
        begin
            n_errors++;
            $display("%s: unexpected L2 write to address %h", test_name, got.addr);
        end
        else
        begin
            check_value("l2 write", exp_q[idx], got);
            exp_q.delete(idx);
        end
    endtask

    ////////////////////
    // L2 grant, compare and monitors

    // req and write contents depend on DUT state only, so the falling edge sees them settled
    initial
    begin
        l2_gnt = 1'b1;
        forever
        begin
            @(negedge clk);
            l2_gnt = gnt_random ? ($urandom_range(3) == 0) : 1'b1;
            if (l2_req && l2_gnt)
                compare_write(l2_wr);
            if (u_dut.fifo_full)
            begin
                full_seen = 1'b1;
                check_value("ready while FIFO full", '0, ch_ready);
            end
            for (int i = 0; i < udma_rx_pkg::N_CH; i++)
            begin
                if (ch_event[i])
                    event_count[i]++;
            end
        end
    end

    task automatic cfg_write(input int ch, input logic [1:0] ofs, input logic [31:0] data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = {ch[1:0], ofs};
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic start_channel(input int ch, input logic [15:0] start, input int size,
                                 input logic cont);
        int t;
        logic ok;
        cfg_write(ch, udma_rx_pkg::REG_SADDR, {16'h0, start});
        cfg_write(ch, udma_rx_pkg::REG_SIZE, size);
        cfg_write(ch, udma_rx_pkg::REG_CTRL, {29'h0, 1'b1, cont, 1'b1});   // clr restarts it
        ok = 1'b0;
        for (t = 0; t < START_TIMEOUT && !ok; t++)
        begin
            @(negedge clk);
            ok = ch_status[ch].en && ch_status[ch].curr_addr == start
                 && ch_status[ch].bytes_left == size;
        end
        if (!ok)
        begin
            n_errors++;
            $display("%s: channel %0d did not load its start address", test_name, ch);
        end
    endtask

    // offers beats one after the other and books the expected writes of each accepted one
    task automatic run_channel(input int ch, input logic [15:0] start, input int size,
                               input udma_rx_pkg::datasize_e ds, input int passes);
        int p;
        int t;
        int left;
        int cnt;
        logic [15:0] addr;
        logic [31:0] d;
        logic got;
        udma_rx_pkg::l2_wr_t w0;
        udma_rx_pkg::l2_wr_t w1;
        @(negedge clk);
        for (p = 0; p < passes; p++)
        begin
            addr = start;
            left = size;
            while (left > 0)
            begin
                d                  = $urandom;
                ch_in[ch].valid    = 1'b1;
                ch_in[ch].data     = d;
                ch_in[ch].datasize = ds;
                got = 1'b0;
                for (t = 0; t < BEAT_TIMEOUT && !got; t++)
                begin
                    #SETTLE_NS;     // let every channel drive before ready is read
                    got = ch_ready[ch];
                    @(negedge clk);
                end
                if (!got)
                begin
                    n_errors++;
                    $display("%s: channel %0d beat was not accepted in time", test_name, ch);
                    ch_in[ch].valid = 1'b0;
                    return;
                end
                cnt = expected_writes(addr, d, ds, left, w0, w1);
                exp_q.push_back(w0);
                if (cnt == 2)
                    exp_q.push_back(w1);
                addr = addr + beat_size_bytes(ds);
                left = left - beat_size_bytes(ds);
            end
        end
        ch_in[ch].valid = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        for (t = 0; t < DRAIN_TIMEOUT && (exp_q.size() != 0 || l2_req); t++)
            @(negedge clk);
        if (exp_q.size() != 0 || l2_req)
        begin
            n_errors++;
            $display("%s: %0d expected writes never arrived", test_name, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic check_done(input int ch, input int events, input logic active);
        check_value($sformatf("ch%0d events", ch), events, event_count[ch]);
        check_value($sformatf("ch%0d en", ch), active, ch_status[ch].en);
        check_value($sformatf("ch%0d pending", ch), active, ch_status[ch].pending);
    endtask

    ////////////////////
    // test sequence

    initial
    begin
        void'($urandom(32'h5da));
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        ch_in      = '0;
        gnt_random = 1'b0;
        full_seen  = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        test_name  = "reset";
        foreach (event_count[i])
            event_count[i] = 0;
        for (int t = 0; t < RESET_TIMEOUT && !rstn; t++)
            @(negedge clk);
        if (!rstn)
        begin
            n_errors++;
            $display("reset was never released");
        end
        check_value("l2_req", 0, l2_req);
        check_value("ready", 0, ch_ready);
        check_value("event", 0, ch_event);
        for (int i = 0; i < udma_rx_pkg::N_CH; i++)
            check_done(i, 0, 1'b0);

        test_name = "aligned_word";
        start_channel(0, 16'h0100, 16, 1'b0);
        run_channel(0, 16'h0100, 16, udma_rx_pkg::SIZE_WORD, 1);
        wait_drain();
        check_done(0, 1, 1'b0);

        test_name = "byte_half_lanes";
        start_channel(1, 16'h0201, 5, 1'b0);
        run_channel(1, 16'h0201, 5, udma_rx_pkg::SIZE_BYTE, 1);
        start_channel(2, 16'h0302, 6, 1'b0);
        run_channel(2, 16'h0302, 6, udma_rx_pkg::SIZE_HALF, 1);
        wait_drain();

        test_name = "unaligned_split";
        start_channel(0, 16'h0101, 12, 1'b0);
        run_channel(0, 16'h0101, 12, udma_rx_pkg::SIZE_WORD, 1);
        start_channel(3, 16'h0403, 8, 1'b0);
        run_channel(3, 16'h0403, 8, udma_rx_pkg::SIZE_HALF, 1);
        wait_drain();

        test_name = "trim_last";
        start_channel(1, 16'h0500, 10, 1'b0);
        run_channel(1, 16'h0500, 10, udma_rx_pkg::SIZE_WORD, 1);
        start_channel(2, 16'h0601, 5, 1'b0);
        run_channel(2, 16'h0601, 5, udma_rx_pkg::SIZE_HALF, 1);
        wait_drain();

        test_name = "four_channels";
        foreach (event_count[i])
            event_count[i] = 0;
        start_channel(0, 16'h1000, 16, 1'b1);
        start_channel(1, 16'h2001, 10, 1'b0);
        start_channel(2, 16'h3003, 7, 1'b0);
        start_channel(3, 16'h4002, 12, 1'b0);
        fork
            run_channel(0, 16'h1000, 16, udma_rx_pkg::SIZE_WORD, 2);
            run_channel(1, 16'h2001, 10, udma_rx_pkg::SIZE_HALF, 1);
            run_channel(2, 16'h3003, 7, udma_rx_pkg::SIZE_BYTE, 1);
            run_channel(3, 16'h4002, 12, udma_rx_pkg::SIZE_WORD, 1);
        join
        wait_drain();
        check_done(0, 2, 1'b1);     // the continuous channel stays armed
        check_done(1, 1, 1'b0);
        check_done(2, 1, 1'b0);
        check_done(3, 1, 1'b0);

        test_name  = "back_pressure";
        gnt_random = 1'b1;
        start_channel(0, 16'h5001, 24, 1'b0);
        start_channel(1, 16'h6000, 9, 1'b0);
        start_channel(2, 16'h7002, 14, 1'b0);
        start_channel(3, 16'h8000, 20, 1'b0);
        fork
            run_channel(0, 16'h5001, 24, udma_rx_pkg::SIZE_WORD, 1);
            run_channel(1, 16'h6000, 9, udma_rx_pkg::SIZE_BYTE, 1);
            run_channel(2, 16'h7002, 14, udma_rx_pkg::SIZE_HALF, 1);
            run_channel(3, 16'h8000, 20, udma_rx_pkg::SIZE_WORD, 1);
        join
        wait_drain();
        if (!full_seen)
        begin
            n_errors++;
            $display("%s: the write FIFO never filled", test_name);
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/udma_rx_pkg.sv
src/udma_rx_cfg_regs.sv
src/udma_rx_ch_addrgen.sv
src/udma_rx_arbiter.sv
src/udma_rx_fifo.sv
src/udma_rx_l2_write.sv
src/udma_rx_top.sv
verif/tb_clkgen.sv
verif/tb_udma_rx.sv
